// ==== bypass_controller.sv ====
`timescale 1ns/1ps

module bypass_controller (
    input  logic                          clk,
    input  logic                          reset,
    // host side
    input  logic                          bypass_enable,   // level
    input  stim_ctrl_pkg::cmd_word_t      command_data,
    input  logic                          command_valid,   // strobe
    input  stim_ctrl_pkg::spike_count_t   spike_counts [0:stim_ctrl_pkg::NUM_GROUPS-1],
    input  logic                          spike_valid,     // strobe
    // programming ports A1..D2
    output stim_ctrl_pkg::prog_channel_t  prog_channel [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output stim_ctrl_pkg::prog_addr_t     prog_address [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output stim_ctrl_pkg::prog_module_t   prog_module  [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output stim_ctrl_pkg::prog_word_t     prog_word    [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output logic                          prog_trig    [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    // status back to host
    output stim_ctrl_pkg::cmd_word_t      response_data,
    output logic                          response_valid,
    output logic                          busy,
    output stim_ctrl_pkg::result_count_t  win_counter,
    output stim_ctrl_pkg::result_count_t  lose_counter,
    output stim_ctrl_pkg::paddle_t        paddle_control
);

    // --------------------
    // internal nets
    // --------------------
    logic                         command_accept;
    stim_ctrl_pkg::cmd_word_t     command_reg;
    stim_ctrl_pkg::group_func_t   group_funcs [0:stim_ctrl_pkg::NUM_GROUPS-1];
    stim_ctrl_pkg::prog_channel_t dec_channel [0:stim_ctrl_pkg::NUM_PROG_PORTS-1];
    stim_ctrl_pkg::prog_addr_t    dec_address [0:stim_ctrl_pkg::NUM_PROG_PORTS-1];
    stim_ctrl_pkg::prog_module_t  dec_module  [0:stim_ctrl_pkg::NUM_PROG_PORTS-1];
    stim_ctrl_pkg::prog_word_t    dec_word    [0:stim_ctrl_pkg::NUM_PROG_PORTS-1];
    logic [stim_ctrl_pkg::NUM_PROG_PORTS-1:0] dec_trig_mask;

    // group function table, written by accepted config commands
    electrode_group_table i_group_table (
        .clk            (clk),
        .reset          (reset),
        .command_accept (command_accept),
        .command_data   (command_data),   // raw word, same edge as accept
        .group_funcs    (group_funcs)
    );

    // spike sums -> paddle
    spike_paddle_control i_paddle (
        .clk            (clk),
        .reset          (reset),
        .bypass_enable  (bypass_enable),
        .spike_valid    (spike_valid),
        .spike_counts   (spike_counts),
        .group_funcs    (group_funcs),
        .paddle_control (paddle_control)
    );

    // command -> port values, combinational
    prog_word_decoder i_decoder (
        .command        (command_reg),
        .dec_channel    (dec_channel),
        .dec_address    (dec_address),
        .dec_module     (dec_module),
        .dec_word       (dec_word),
        .dec_trig_mask  (dec_trig_mask)
    );

    // --------------------
    // sequencer
    // --------------------
    prog_sequencer i_sequencer (
        .clk            (clk),
        .reset          (reset),
        .bypass_enable  (bypass_enable),
        .command_valid  (command_valid),
        .command_data   (command_data),
        .command_accept (command_accept),
        .command_reg    (command_reg),
        .dec_channel    (dec_channel),
        .dec_address    (dec_address),
        .dec_module     (dec_module),
        .dec_word       (dec_word),
        .dec_trig_mask  (dec_trig_mask),
        .prog_channel   (prog_channel),
        .prog_address   (prog_address),
        .prog_module    (prog_module),
        .prog_word      (prog_word),
        .prog_trig      (prog_trig),
        .response_data  (response_data),
        .response_valid (response_valid),
        .busy           (busy),
        .win_counter    (win_counter),
        .lose_counter   (lose_counter)
    );

endmodule

// ==== electrode_group_table.sv ====
`timescale 1ns/1ps

module electrode_group_table (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      command_accept,  // one cycle, from sequencer
    input  stim_ctrl_pkg::cmd_word_t  command_data,    // raw host word
    output stim_ctrl_pkg::group_func_t group_funcs [0:stim_ctrl_pkg::NUM_GROUPS-1]
);

    // --------------------
    // command field split
    // --------------------
    stim_ctrl_pkg::cmd_type_t   cmd_type;
    stim_ctrl_pkg::group_id_t   cmd_group;
    stim_ctrl_pkg::group_func_t cmd_func;
    logic                       wr_en;

    assign cmd_type  = command_data[stim_ctrl_pkg::TYPE_LSB +: $bits(stim_ctrl_pkg::cmd_type_t)];
    assign cmd_group = command_data[stim_ctrl_pkg::GROUP_LSB +: $bits(stim_ctrl_pkg::group_id_t)];
    // raw 2-bit field, code 3 goes in unchanged
    assign cmd_func  = stim_ctrl_pkg::group_func_t'(
        command_data[stim_ctrl_pkg::FUNC_LSB +: $bits(stim_ctrl_pkg::group_func_t)]);

    // write only on config commands with a group in range
    assign wr_en = command_accept
                && (cmd_type == stim_ctrl_pkg::CMD_GROUP_CFG)
                && (cmd_group < stim_ctrl_pkg::NUM_GROUPS);

    // --------------------
    // table storage
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int g = 0; g < stim_ctrl_pkg::NUM_GROUPS; g++) begin
                group_funcs[g] <= stim_ctrl_pkg::GF_COLLECT;  // all collecting
            end
        end else begin
            for (int g = 0; g < stim_ctrl_pkg::NUM_GROUPS; g++) begin
                if (wr_en && (cmd_group == stim_ctrl_pkg::group_id_t'(g))) begin
                    group_funcs[g] <= cmd_func;   // one entry per command
                end
            end
        end
    end

endmodule

// ==== prog_sequencer.sv ====
`timescale 1ns/1ps

module prog_sequencer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          bypass_enable,
    input  logic                          command_valid,   // one cycle strobe
    input  stim_ctrl_pkg::cmd_word_t      command_data,
    output logic                          command_accept,  // to group table
    output stim_ctrl_pkg::cmd_word_t      command_reg,     // to decoder
    input  stim_ctrl_pkg::prog_channel_t  dec_channel [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    input  stim_ctrl_pkg::prog_addr_t     dec_address [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    input  stim_ctrl_pkg::prog_module_t   dec_module  [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    input  stim_ctrl_pkg::prog_word_t     dec_word    [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    input  logic [stim_ctrl_pkg::NUM_PROG_PORTS-1:0] dec_trig_mask,
    output stim_ctrl_pkg::prog_channel_t  prog_channel [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output stim_ctrl_pkg::prog_addr_t     prog_address [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output stim_ctrl_pkg::prog_module_t   prog_module  [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output stim_ctrl_pkg::prog_word_t     prog_word    [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output logic                          prog_trig    [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output stim_ctrl_pkg::cmd_word_t      response_data,
    output logic                          response_valid,
    output logic                          busy,
    output stim_ctrl_pkg::result_count_t  win_counter,
    output stim_ctrl_pkg::result_count_t  lose_counter
);

    stim_ctrl_pkg::seq_state_t state;
    stim_ctrl_pkg::seq_state_t next_state;

    // --------------------
    // acceptance / capture
    // --------------------
    // only in idle, anything else is dropped without notice
    assign command_accept = command_valid && bypass_enable
                         && (state == stim_ctrl_pkg::S_IDLE);

    always_ff @(posedge clk) begin
        if (command_accept) begin
            command_reg <= command_data;   // held until the next accept
        end
    end

    // --------------------
    // state machine
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            stim_ctrl_pkg::S_IDLE:    if (command_accept) next_state = stim_ctrl_pkg::S_PROCESS;
            stim_ctrl_pkg::S_PROCESS: next_state = stim_ctrl_pkg::S_SEND;
            stim_ctrl_pkg::S_SEND:    next_state = stim_ctrl_pkg::S_WAIT;
            stim_ctrl_pkg::S_WAIT:    next_state = stim_ctrl_pkg::S_DONE;
            stim_ctrl_pkg::S_DONE:    next_state = stim_ctrl_pkg::S_IDLE;
            default:                  next_state = stim_ctrl_pkg::S_IDLE;
        endcase
    end

    // --------------------
    // registered outputs
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= stim_ctrl_pkg::S_IDLE;
            busy           <= 1'b0;
            response_valid <= 1'b0;
            response_data  <= '0;
            win_counter    <= '0;
            lose_counter   <= '0;
            for (int i = 0; i < stim_ctrl_pkg::NUM_PROG_PORTS; i++) begin
                prog_channel[i] <= '0;
                prog_address[i] <= '0;
                prog_module[i]  <= '0;
                prog_word[i]    <= '0;
                prog_trig[i]    <= 1'b0;
            end
        end else begin
            state          <= next_state;
            response_valid <= 1'b0;                   // pulse
            for (int i = 0; i < stim_ctrl_pkg::NUM_PROG_PORTS; i++) begin
                prog_trig[i] <= 1'b0;                 // pulse
            end

            case (state)
                stim_ctrl_pkg::S_PROCESS: begin
                    busy <= 1'b1;                     // edge N+1
                end
                stim_ctrl_pkg::S_SEND: begin
                    // edge N+2, load and fire the triggered ports only
                    for (int i = 0; i < stim_ctrl_pkg::NUM_PROG_PORTS; i++) begin
                        if (dec_trig_mask[i]) begin
                            prog_channel[i] <= dec_channel[i];
                            prog_address[i] <= dec_address[i];
                            prog_module[i]  <= dec_module[i];
                            prog_word[i]    <= dec_word[i];
                            prog_trig[i]    <= 1'b1;
                        end
                    end
                end
                stim_ctrl_pkg::S_DONE: begin
                    // edge N+4, response and score
                    busy           <= 1'b0;
                    response_valid <= 1'b1;
                    response_data  <= command_reg & stim_ctrl_pkg::RESP_MASK;
                    if (command_reg[stim_ctrl_pkg::WIN_BIT]) begin
                        win_counter  <= win_counter + 1'b1;    // wraps
                    end else begin
                        lose_counter <= lose_counter + 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== prog_word_decoder.sv ====
`timescale 1ns/1ps

module prog_word_decoder (
    input  stim_ctrl_pkg::cmd_word_t     command,   // captured command
    output stim_ctrl_pkg::prog_channel_t dec_channel [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output stim_ctrl_pkg::prog_addr_t    dec_address [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output stim_ctrl_pkg::prog_module_t  dec_module  [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output stim_ctrl_pkg::prog_word_t    dec_word    [0:stim_ctrl_pkg::NUM_PROG_PORTS-1],
    output logic [stim_ctrl_pkg::NUM_PROG_PORTS-1:0] dec_trig_mask
);

    stim_ctrl_pkg::cmd_type_t cmd_type;

    assign cmd_type = command[stim_ctrl_pkg::TYPE_LSB +: $bits(stim_ctrl_pkg::cmd_type_t)];

    // --------------------
    // per-port decode
    // --------------------
    always_comb begin
        // defaults, zero everywhere and nothing triggered
        dec_trig_mask = '0;
        for (int i = 0; i < stim_ctrl_pkg::NUM_PROG_PORTS; i++) begin
            dec_channel[i] = '0;
            dec_address[i] = '0;
            dec_module[i]  = '0;
            dec_word[i]    = '0;
        end

        if (cmd_type == stim_ctrl_pkg::CMD_GROUP_CFG) begin
            // group config hits every port, module = port number
            dec_trig_mask = '1;
            for (int i = 0; i < stim_ctrl_pkg::NUM_PROG_PORTS; i++) begin
                dec_module[i] = stim_ctrl_pkg::prog_module_t'(i);
            end
        end else begin
            // everything else goes to A1 only
            dec_trig_mask[stim_ctrl_pkg::PORT_A1] = 1'b1;
            dec_address[stim_ctrl_pkg::PORT_A1]   = stim_ctrl_pkg::START_STIM_ADDR;
            case (cmd_type)
                stim_ctrl_pkg::CMD_GAME_DATA: begin
                    dec_word[stim_ctrl_pkg::PORT_A1] = stim_ctrl_pkg::WORD_GAME;
                end
                stim_ctrl_pkg::CMD_SPIKE_DATA: begin
                    dec_word[stim_ctrl_pkg::PORT_A1] = stim_ctrl_pkg::WORD_SPIKE;
                end
                stim_ctrl_pkg::CMD_CONTROL: begin
                    dec_word[stim_ctrl_pkg::PORT_A1] = stim_ctrl_pkg::WORD_CONTROL;
                end
                default: begin
                    // unknown type, safe shutdown word
                    dec_word[stim_ctrl_pkg::PORT_A1] = stim_ctrl_pkg::WORD_SHUTDOWN;
                end
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile and run with Verilator, result taken from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_bypass_controller \
    -f sources.f -o sim_tb > sim.log 2>&1 &&
    ./obj_dir/sim_tb >> sim.log 2>&1 ||
    { echo "build or run error, see sim.log"; exit 1; }
grep -q "SIMULATION FAILED" sim.log && { echo "fail, see sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
echo "pass"

// ==== sources.f ====
stim_ctrl_pkg.sv
electrode_group_table.sv
spike_paddle_control.sv
prog_word_decoder.sv
prog_sequencer.sv
bypass_controller.sv
tb_bypass_controller.sv

// ==== spike_paddle_control.sv ====
`timescale 1ns/1ps

module spike_paddle_control (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       bypass_enable,  // qualifies the strobe
    input  logic                       spike_valid,    // one cycle
    input  stim_ctrl_pkg::spike_count_t spike_counts [0:stim_ctrl_pkg::NUM_GROUPS-1],
    input  stim_ctrl_pkg::group_func_t  group_funcs  [0:stim_ctrl_pkg::NUM_GROUPS-1],
    output stim_ctrl_pkg::paddle_t      paddle_control
);

    // --------------------
    // masked side sums
    // --------------------
    stim_ctrl_pkg::spike_sum_t sum_a1;   // groups 0..3
    stim_ctrl_pkg::spike_sum_t sum_a2;   // groups 4..7
    logic                      a1_wins;
    logic                      update;

    always_comb begin
        sum_a1 = '0;
        sum_a2 = '0;
        for (int i = 0; i < stim_ctrl_pkg::NUM_GROUPS; i++) begin
            // only collecting groups count, stim / high-z / code 3 drop out
            if (group_funcs[i] == stim_ctrl_pkg::GF_COLLECT) begin
                if (i < stim_ctrl_pkg::GROUPS_PER_SIDE) begin
                    sum_a1 = sum_a1 + stim_ctrl_pkg::spike_sum_t'(spike_counts[i]);
                end else begin
                    sum_a2 = sum_a2 + stim_ctrl_pkg::spike_sum_t'(spike_counts[i]);
                end
            end
        end
    end

    assign a1_wins = (sum_a1 > sum_a2);          // strict, ties go down
    assign update  = spike_valid && bypass_enable;

    // --------------------
    // paddle register
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            paddle_control <= '0;                // neither direction
        end else if (update) begin
            if (a1_wins) begin
                paddle_control <= stim_ctrl_pkg::PADDLE_UP;
            end else begin
                paddle_control <= stim_ctrl_pkg::PADDLE_DOWN;
            end
        end
        // no strobe or bypass off -> hold
    end

endmodule

// ==== stim_ctrl_pkg.sv ====
package stim_ctrl_pkg;

    // --------------------
    // word and field widths
    // --------------------
    typedef logic [31:0] cmd_word_t;      // host command / response
    typedef logic [3:0]  cmd_type_t;      // bits 31..28
    typedef logic [3:0]  group_id_t;      // bits 27..24
    typedef logic [3:0]  prog_channel_t;
    typedef logic [3:0]  prog_addr_t;
    typedef logic [4:0]  prog_module_t;
    typedef logic [15:0] prog_word_t;
    typedef logic [15:0] spike_count_t;   // one group
    typedef logic [17:0] spike_sum_t;     // four groups, no overflow
    typedef logic [7:0]  result_count_t;  // wraps
    typedef logic [1:0]  paddle_t;        // [1] up, [0] down

    // group function, code 3 kept as is and treated as not collecting
    typedef enum logic [1:0] {
        GF_COLLECT = 2'd0,
        GF_STIM    = 2'd1,
        GF_HIGH_Z  = 2'd2
    } group_func_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PROCESS,
        S_SEND,
        S_WAIT,
        S_DONE
    } seq_state_t;

    // --------------------
    // sizes
    // --------------------
    localparam int NUM_PROG_PORTS  = 8;   // A1 A2 B1 B2 C1 C2 D1 D2
    localparam int NUM_GROUPS      = 8;
    localparam int GROUPS_PER_SIDE = 4;   // side A1 = 0..3, A2 = 4..7
    localparam int PORT_A1         = 0;

    // command field positions
    localparam int TYPE_LSB  = 28;
    localparam int GROUP_LSB = 24;
    localparam int FUNC_LSB  = 22;
    localparam int WIN_BIT   = 31;        // top bit set means a win

    localparam cmd_word_t RESP_MASK = 32'hFFFF_FFF0;  // response drops low nibble

    // --------------------
    // command codes
    // --------------------
    localparam cmd_type_t CMD_GROUP_CFG  = 4'd1;
    localparam cmd_type_t CMD_GAME_DATA  = 4'd2;
    localparam cmd_type_t CMD_SPIKE_DATA = 4'd3;
    localparam cmd_type_t CMD_CONTROL    = 4'd4;

    // programming constants
    localparam prog_addr_t START_STIM_ADDR = 4'd4;
    localparam prog_word_t WORD_GAME       = 16'h0011;
    localparam prog_word_t WORD_SPIKE      = 16'h0012;
    localparam prog_word_t WORD_CONTROL    = 16'h0013;
    localparam prog_word_t WORD_SHUTDOWN   = 16'h0000;

    localparam paddle_t PADDLE_UP   = 2'b10;
    localparam paddle_t PADDLE_DOWN = 2'b01;

endpackage

// ==== tb_bypass_controller.sv ====
`timescale 1ns/1ps

module tb_bypass_controller;

    // --------------------
    // run length
    // --------------------
    localparam int NUM_CMDS    = 12;   // commands including dropped ones
    localparam int NUM_STROBES = 20;   // spike strobes
    localparam int TIMEOUT_NS  = (8 + NUM_CMDS * 14 + NUM_STROBES * 3 + 100) * 20;

    logic                         clk, reset, bypass_enable, command_valid, spike_valid;
    stim_ctrl_pkg::cmd_word_t     command_data, response_data;
    stim_ctrl_pkg::spike_count_t  spike_counts [0:7];
    stim_ctrl_pkg::prog_channel_t prog_channel [0:7];
    stim_ctrl_pkg::prog_addr_t    prog_address [0:7];
    stim_ctrl_pkg::prog_module_t  prog_module  [0:7];
    stim_ctrl_pkg::prog_word_t    prog_word    [0:7];
    logic                         prog_trig    [0:7];
    logic                         response_valid, busy;
    stim_ctrl_pkg::result_count_t win_counter, lose_counter;
    stim_ctrl_pkg::paddle_t       paddle_control;

    logic [7:0] trig_vec;           // prog_trig packed
    logic [1:0] ref_funcs [0:7];    // reference group table with 0 as collect
    logic [7:0] ref_win, ref_lose;
    stim_ctrl_pkg::paddle_t ref_paddle;   // expected paddle register
    // 0xA is unknown and has the top bit set
    logic [3:0] cmd_types [5] = '{4'h1, 4'h2, 4'h3, 4'h4, 4'hA};
    integer     seed;
    int         errors, tests, failed_tests, test_start;

    bypass_controller i_dut (.*);

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            trig_vec[i] = prog_trig[i];
        end
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;      // 20 ns period
    end

    // trigger and response are single-cycle pulses
    assert property (@(posedge clk) disable iff (reset)
                     (trig_vec != 8'h00) |=> (trig_vec == 8'h00))
        else begin
            $display("prog_trig stayed high for more than one cycle at %0t", $time);
            errors++;
        end
    assert property (@(posedge clk) disable iff (reset) response_valid |=> !response_valid)
        else begin
            $display("response_valid stayed high for more than one cycle at %0t", $time);
            errors++;
        end

    // --------------------
    // helpers
    // --------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors == test_start) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    // one command through the whole sequence with N as the accept edge
    task automatic run_command(input stim_ctrl_pkg::cmd_word_t cmd, input logic intrude);
        logic [3:0]  t;
        logic [7:0]  mask;
        logic [15:0] a1_word;
        t = cmd[31:28];
        mask = (t == 4'h1) ? 8'hff : 8'h01;     // config hits every port and the rest A1 only
        case (t)
            4'h2:    a1_word = 16'h0011;
            4'h3:    a1_word = 16'h0012;
            4'h4:    a1_word = 16'h0013;
            default: a1_word = 16'h0000;         // shutdown and config words are both zero
        endcase
        @(negedge clk);
        command_valid = 1'b1;
        command_data  = cmd;
        @(negedge clk);                          // after N
        command_valid = 1'b0;
        if (t == 4'h1 && !cmd[27]) ref_funcs[cmd[26:24]] = cmd[23:22];
        check_value("busy", 0, busy);
        @(negedge clk);                          // after N+1
        check_value("busy", 1, busy);
        check_value("prog_trig", 0, trig_vec);
        if (intrude) begin
            command_valid = 1'b1;                // group 0 to high-z must be dropped
            command_data  = {4'h1, 4'h0, 2'b10, 22'h0};
        end
        @(negedge clk);                          // after N+2
        command_valid = 1'b0;
        check_value("prog_trig", mask, trig_vec);
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) begin
                // module is the port number for config, and port 0 otherwise
                check_value($sformatf("prog_channel[%0d]", i), 0, prog_channel[i]);
                check_value($sformatf("prog_address[%0d]", i), (t == 4'h1) ? 0 : 4,
                            prog_address[i]);
                check_value($sformatf("prog_module[%0d]", i), i, prog_module[i]);
                check_value($sformatf("prog_word[%0d]", i), a1_word, prog_word[i]);
            end else begin
                // untriggered port still holds what the last config loaded
                check_value($sformatf("prog_module[%0d]", i), i, prog_module[i]);
                check_value($sformatf("prog_word[%0d]", i), 0, prog_word[i]);
            end
        end
        @(negedge clk);                          // after N+3
        check_value("prog_trig", 0, trig_vec);
        check_value("busy", 1, busy);
        check_value("response_valid", 0, response_valid);
        @(negedge clk);                          // after N+4
        if (cmd[31]) ref_win = ref_win + 8'd1;
        else ref_lose = ref_lose + 8'd1;
        check_value("busy", 0, busy);
        check_value("response_valid", 1, response_valid);
        check_value("response_data", {cmd[31:4], 4'h0}, response_data);
        check_value("win_counter", ref_win, win_counter);
        check_value("lose_counter", ref_lose, lose_counter);
        @(negedge clk);                          // after N+5
        check_value("response_valid", 0, response_valid);
    endtask

    // nothing may fire for a while
    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("prog_trig", 0, trig_vec);
            check_value("response_valid", 0, response_valid);
            check_value("busy", 0, busy);
        end
        check_value("win_counter", ref_win, win_counter);
        check_value("lose_counter", ref_lose, lose_counter);
    endtask

    task automatic randomize_counts();
        logic [31:0] rnd;
        @(negedge clk);
        for (int g = 0; g < 8; g++) begin
            rnd = $random(seed);
            spike_counts[g] = rnd[15:0];
        end
    endtask

    task automatic set_counts(input logic [15:0] a1_val, input logic [15:0] a2_val);
        @(negedge clk);
        for (int g = 0; g < 8; g++) begin
            spike_counts[g] = (g < 4) ? a1_val : a2_val;   // side A1 is 0..3
        end
    endtask

    task automatic spike_strobe(input logic enable);
        int a1, a2;
        a1 = 0;
        a2 = 0;
        for (int g = 0; g < 8; g++) begin
            if (ref_funcs[g] == 2'd0 && g < 4) a1 += spike_counts[g];
            if (ref_funcs[g] == 2'd0 && g >= 4) a2 += spike_counts[g];
        end
        // disabled strobe leaves the reference as it was
        if (enable) begin
            if (a1 > a2) ref_paddle = 2'b10;     // up
            else ref_paddle = 2'b01;             // down on ties too
        end
        bypass_enable = enable;
        spike_valid   = 1'b1;
        @(negedge clk);
        spike_valid   = 1'b0;
        bypass_enable = 1'b1;
        check_value("paddle_control", ref_paddle, paddle_control);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        logic [31:0]              rnd;
        stim_ctrl_pkg::cmd_word_t word;
        reset         = 1'b1;
        bypass_enable = 1'b0;
        command_valid = 1'b0;
        command_data  = '0;
        spike_valid   = 1'b0;
        for (int g = 0; g < 8; g++) begin
            spike_counts[g] = '0;
            ref_funcs[g]    = 2'd0;
        end
        ref_win      = '0;
        ref_lose     = '0;
        ref_paddle   = 2'b00;
        seed         = 32'h3fe9c84e;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        test_start   = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset         = 1'b0;
        bypass_enable = 1'b1;
        check_value("prog_trig", 0, trig_vec);
        check_value("response_valid", 0, response_valid);
        check_value("busy", 0, busy);
        check_value("paddle_control", 0, paddle_control);
        check_value("win_counter", 0, win_counter);
        check_value("lose_counter", 0, lose_counter);
        close_test("reset values");

        foreach (cmd_types[k]) begin
            rnd  = $random(seed);
            word = (cmd_types[k] == 4'h1) ? {4'h1, 4'h5, 2'b00, rnd[21:0]}  // group 5 collect
                                          : {cmd_types[k], rnd[27:0]};
            run_command(word, 1'b0);
            close_test($sformatf("command type %h", cmd_types[k]));
        end

        // group 1 to high-z with bypass off must be dropped
        @(negedge clk);
        bypass_enable = 1'b0;
        command_valid = 1'b1;
        command_data  = {4'h1, 4'h1, 2'b10, 22'h0};
        @(negedge clk);
        command_valid = 1'b0;
        bypass_enable = 1'b1;
        expect_quiet(6);
        close_test("dropped while disabled");
        run_command({4'h2, 28'h0abcdef}, 1'b1);
        expect_quiet(6);
        close_test("dropped while busy");

        // --------------------
        // paddle
        // --------------------
        set_counts(16'd100, 16'd80);             // 400 vs 320 -> up
        spike_strobe(1'b1);
        repeat (8) begin
            randomize_counts();
            spike_strobe(1'b1);
        end
        set_counts(16'd50, 16'd50);              // tie
        spike_strobe(1'b1);
        close_test("paddle all collecting");
        run_command({4'h1, 4'h0, 2'b10, 22'h0}, 1'b0);   // group 0 high-z
        run_command({4'h1, 4'h1, 2'b01, 22'h0}, 1'b0);   // group 1 stim
        run_command({4'h1, 4'h6, 2'b11, 22'h0}, 1'b0);   // group 6 code 3
        set_counts(16'd100, 16'd80);             // now 200 vs 240 -> down
        spike_strobe(1'b1);
        repeat (6) begin
            randomize_counts();
            spike_strobe(1'b1);
        end
        close_test("paddle masked groups");
        run_command({4'h1, 4'hC, 2'b10, 22'h0}, 1'b0);   // group 12 writes nothing
        set_counts(16'd100, 16'd80);
        spike_strobe(1'b1);
        close_test("paddle invalid group");
        set_counts(16'd1000, 16'd0);             // would go up if sampled
        spike_strobe(1'b0);
        close_test("paddle hold when disabled");

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
